//--- verilog/eth_frame_pkg.sv
package eth_frame_pkg;

    typedef logic [47:0] mac_addr_t;  // six octets, first octet in the top bits
    typedef logic [31:0] ip_addr_t;   // dotted quad, first quad in the top bits
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] len16_t;     // shared by length and checksum fields
    typedef logic [7:0]  byte_t;

    localparam logic [15:0] ETH_TYPE_IPV4    = 16'h0800;
    localparam logic [7:0]  IPV4_PROTO_UDP   = 8'h11;
    localparam logic [15:0] IPV4_VER_IHL_TOS = 16'h4500;  // version 4, five header words, tos 0
    localparam logic [7:0]  IPV4_TTL         = 8'hff;

    localparam int ETH_HDR_BYTES  = 14;  // dest mac, src mac and ethertype
    localparam int IPV4_HDR_BYTES = 20;  // no options are ever sent
    localparam int UDP_HDR_BYTES  = 8;

    localparam int ETH_FRAME_MAX_BYTES = 1518;
    localparam int ETH_FRAME_MIN_BYTES = 64;

endpackage

//--- verilog/udp_pktzr_pkg.sv
package udp_pktzr_pkg;

    localparam int SEQ_NUM_BYTES = 4;
    typedef logic [8*SEQ_NUM_BYTES-1:0] seq_num_t;  // sent most significant byte first

    localparam int HDR_BYTES = eth_frame_pkg::ETH_HDR_BYTES + eth_frame_pkg::IPV4_HDR_BYTES +
                               eth_frame_pkg::UDP_HDR_BYTES;  // 42 bytes ahead of the udp payload

    localparam int FIFO_ADDR_BITS = 11;  // 2048 words
    localparam int FIFO_AFULL_LVL = 2**FIFO_ADDR_BITS - eth_frame_pkg::ETH_FRAME_MAX_BYTES;
    localparam int FRAME_CNT_BITS =
        $clog2(2**FIFO_ADDR_BITS / eth_frame_pkg::ETH_FRAME_MIN_BYTES + 1);  // must reach 32

    typedef struct packed {
        logic                 eof;   // set on the final byte of a frame
        eth_frame_pkg::byte_t data;
    } fifo_word_t;

    typedef enum logic [2:0] {
        IDLE,
        ETH_HDR,
        IPV4_HDR,
        UDP_HDR,
        SEQ_NUM,
        PAYLOAD
    } builder_state_e;

endpackage

//--- verilog/frame_wr_if.sv
`timescale 1ns/1ps

interface frame_wr_if;

    logic                     wr;     // one word written per high cycle
    udp_pktzr_pkg::fifo_word_t word;
    logic                     afull;  // room left for exactly one maximum frame
    logic                     full;

    modport builder (
        output wr,
        output word,
        input  afull
    );

    modport buffer (
        input  wr,
        input  word,
        output afull,
        output full
    );

endinterface

//--- verilog/ipv4_csum_pipe.sv
`timescale 1ns/1ps

module ipv4_csum_pipe (
    input  logic                   i_txmac_clk,
    input  logic                   i_txmac_srst,
    input  logic                   i_start,
    input  eth_frame_pkg::len16_t  i_total_len,
    input  eth_frame_pkg::ip_addr_t i_src_ip,
    input  eth_frame_pkg::ip_addr_t i_dest_ip,
    output eth_frame_pkg::len16_t  o_csum
);

    logic [2:0]  vld;                   // valid flags for the first three stages
    logic [16:0] s1_fix, s1_src, s1_dst;  // id, flags and fragment are zero and skipped
    logic [17:0] s2_a, s2_b;
    logic [18:0] s3_sum;
    logic [16:0] fold_1;                // first carry fold can carry again
    logic [15:0] fold_2;

    assign fold_1 = {1'b0, s3_sum[15:0]} + 17'(s3_sum[18:16]);
    assign fold_2 = fold_1[15:0] + 16'(fold_1[16]);  // second fold cannot overflow

    always_ff @(posedge i_txmac_clk) begin
        if (i_txmac_srst) begin
            vld <= '0;
        end else begin
            vld <= {vld[1:0], i_start};  // one computation in flight at a time
        end
    end

    always_ff @(posedge i_txmac_clk) begin
        s1_fix <= 17'(eth_frame_pkg::IPV4_VER_IHL_TOS) + 17'(i_total_len);  // stage 1 partial sums
        s1_src <= 17'(i_src_ip[31:16]) + 17'(i_src_ip[15:0]);
        s1_dst <= 17'(i_dest_ip[31:16]) + 17'(i_dest_ip[15:0]);
        s2_a   <= 18'(s1_fix) +
                  18'({eth_frame_pkg::IPV4_TTL, eth_frame_pkg::IPV4_PROTO_UDP});  // stage 2 adds ttl
        s2_b   <= 18'(s1_src) + 18'(s1_dst);
        s3_sum <= 19'(s2_a) + 19'(s2_b);       // stage 3
        if (vld[2]) begin
            o_csum <= ~fold_2;  // stage 4 holds its result until the next start reaches here
        end
    end

endmodule

//--- verilog/udp_frame_builder.sv
`timescale 1ns/1ps

module udp_frame_builder (
    input  logic                      i_txmac_clk,
    input  logic                      i_txmac_srst,
    input  logic                      i_start,
    output logic                      o_start_ack,
    output logic                      o_done,
    output logic                      o_data_byte_rd,
    input  logic                      i_data_byte_vld,
    input  eth_frame_pkg::byte_t      i_data_byte,
    input  eth_frame_pkg::mac_addr_t  i_dest_mac,
    input  eth_frame_pkg::mac_addr_t  i_src_mac,
    input  eth_frame_pkg::ip_addr_t   i_dest_ip,
    input  eth_frame_pkg::ip_addr_t   i_src_ip,
    input  eth_frame_pkg::udp_port_t  i_dest_port,
    input  eth_frame_pkg::udp_port_t  i_src_port,
    input  eth_frame_pkg::len16_t     i_udp_payload_bytes,
    input  logic                      i_seq_num_prsnt,
    input  udp_pktzr_pkg::seq_num_t   i_seq_num,
    output logic                      o_csum_start,
    output eth_frame_pkg::len16_t     o_total_len,
    input  eth_frame_pkg::len16_t     i_csum,
    frame_wr_if.builder               wr_if
);

    udp_pktzr_pkg::builder_state_e state;
    logic [327:0]                  hdr_sr;     // header bytes 1 to 41, next byte on top
    logic [5:0]                    hdr_cnt;    // header bytes written so far
    eth_frame_pkg::len16_t         pay_cnt;    // 1-based index of the next udp payload byte
    eth_frame_pkg::len16_t         pay_len;    // includes the sequence number bytes
    logic                          seq_prsnt;
    udp_pktzr_pkg::seq_num_t       seq_sr;
    eth_frame_pkg::len16_t         total_len;
    eth_frame_pkg::len16_t         udp_len;
    logic                          pay_last;

    assign total_len = 16'(i_udp_payload_bytes + eth_frame_pkg::IPV4_HDR_BYTES +
                           eth_frame_pkg::UDP_HDR_BYTES);
    assign udp_len   = 16'(i_udp_payload_bytes + eth_frame_pkg::UDP_HDR_BYTES);
    assign pay_last  = (pay_cnt == pay_len);

    always_ff @(posedge i_txmac_clk) begin
        if (i_txmac_srst) begin
            state          <= udp_pktzr_pkg::IDLE;
            o_start_ack    <= 1'b0;
            o_done         <= 1'b0;
            o_data_byte_rd <= 1'b0;
            o_csum_start   <= 1'b0;
            wr_if.wr       <= 1'b0;
        end else begin
            o_start_ack    <= 1'b0;  // single-cycle pulses unless a state says otherwise
            o_csum_start   <= 1'b0;
            o_data_byte_rd <= 1'b0;
            wr_if.wr       <= 1'b0;
            o_done         <= wr_if.wr & wr_if.word.eof;  // one cycle behind the eof write
            case (state)
                udp_pktzr_pkg::IDLE: begin
                    if (i_start && !wr_if.afull) begin  // only start with room for a full frame
                        o_start_ack  <= 1'b1;
                        o_csum_start <= 1'b1;           // pipeline runs beside the eth header
                        o_total_len  <= total_len;
                        wr_if.wr     <= 1'b1;
                        wr_if.word   <= '{eof: 1'b0, data: i_dest_mac[47:40]};
                        hdr_sr       <= {i_dest_mac[39:0], i_src_mac, eth_frame_pkg::ETH_TYPE_IPV4,
                                         eth_frame_pkg::IPV4_VER_IHL_TOS, total_len, 32'h0,
                                         eth_frame_pkg::IPV4_TTL, eth_frame_pkg::IPV4_PROTO_UDP,
                                         16'h0, i_src_ip, i_dest_ip,
                                         i_src_port, i_dest_port, udp_len, 16'h0};
                        hdr_cnt      <= 6'd1;
                        pay_len      <= i_udp_payload_bytes;
                        seq_prsnt    <= i_seq_num_prsnt;
                        seq_sr       <= i_seq_num;
                        state        <= udp_pktzr_pkg::ETH_HDR;
                    end
                end
                udp_pktzr_pkg::ETH_HDR, udp_pktzr_pkg::IPV4_HDR, udp_pktzr_pkg::UDP_HDR: begin
                    wr_if.wr   <= 1'b1;
                    wr_if.word <= '{eof: 1'b0, data: hdr_sr[327:320]};
                    hdr_sr     <= {hdr_sr[319:0], 8'h00};
                    hdr_cnt    <= hdr_cnt + 6'd1;
                    if (hdr_cnt == 6'(eth_frame_pkg::ETH_HDR_BYTES - 1)) begin
                        // last eth byte goes out, checksum lands in ipv4 bytes 10 and 11
                        hdr_sr <= {hdr_sr[319:240], i_csum, hdr_sr[223:0], 8'h00};
                        state  <= udp_pktzr_pkg::IPV4_HDR;
                    end
                    if (hdr_cnt == 6'(eth_frame_pkg::ETH_HDR_BYTES +
                                      eth_frame_pkg::IPV4_HDR_BYTES - 1)) begin
                        state <= udp_pktzr_pkg::UDP_HDR;
                    end
                    if (hdr_cnt == 6'(udp_pktzr_pkg::HDR_BYTES - 1)) begin
                        pay_cnt <= 16'd1;
                        if (seq_prsnt) begin
                            state <= udp_pktzr_pkg::SEQ_NUM;
                        end else begin
                            o_data_byte_rd <= 1'b1;  // ask for payload one cycle early
                            state          <= udp_pktzr_pkg::PAYLOAD;
                        end
                    end
                end
                udp_pktzr_pkg::SEQ_NUM: begin
                    wr_if.wr   <= 1'b1;
                    wr_if.word <= '{eof: pay_last, data: seq_sr[$bits(seq_sr)-1 -: 8]};  // msb first
                    seq_sr     <= seq_sr << 8;
                    pay_cnt    <= pay_cnt + 16'd1;
                    if (pay_last) begin
                        state <= udp_pktzr_pkg::IDLE;  // payload held nothing past the sequence number
                    end else if (pay_cnt == 16'(udp_pktzr_pkg::SEQ_NUM_BYTES)) begin
                        o_data_byte_rd <= 1'b1;
                        state          <= udp_pktzr_pkg::PAYLOAD;
                    end
                end
                udp_pktzr_pkg::PAYLOAD: begin
                    o_data_byte_rd <= 1'b1;
                    if (i_data_byte_vld && o_data_byte_rd) begin  // byte consumed this cycle
                        wr_if.wr   <= 1'b1;
                        wr_if.word <= '{eof: pay_last, data: i_data_byte};
                        pay_cnt    <= pay_cnt + 16'd1;
                        if (pay_last) begin
                            o_data_byte_rd <= 1'b0;
                            state          <= udp_pktzr_pkg::IDLE;
                        end
                    end
                end
                default: state <= udp_pktzr_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- verilog/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo #(
    parameter int ADDR_BITS = udp_pktzr_pkg::FIFO_ADDR_BITS
) (
    input  logic                      i_txmac_clk,
    input  logic                      i_txmac_srst,
    frame_wr_if.buffer                wr_if,
    input  logic                      i_rd,
    output udp_pktzr_pkg::fifo_word_t o_word,
    output logic                      o_vld,
    output logic                      o_avail
);

    localparam int DEPTH     = 2**ADDR_BITS;
    localparam int AFULL_LVL = udp_pktzr_pkg::FIFO_AFULL_LVL + DEPTH -
                               2**udp_pktzr_pkg::FIFO_ADDR_BITS;  // depth minus one max frame
    localparam int CNT_BITS  = udp_pktzr_pkg::FRAME_CNT_BITS + ADDR_BITS -
                               udp_pktzr_pkg::FIFO_ADDR_BITS;

    udp_pktzr_pkg::fifo_word_t mem [DEPTH];
    logic [ADDR_BITS-1:0]      wr_ptr;
    logic [ADDR_BITS-1:0]      rd_ptr;
    logic [ADDR_BITS:0]        fill;     // words stored, reaches DEPTH when full
    logic [CNT_BITS-1:0]       frm_cnt;  // complete frames stored
    logic                      push;
    logic                      pop;

    assign push        = wr_if.wr & ~wr_if.full;  // a write into a full buffer is dropped
    assign pop         = i_rd & o_vld;
    assign o_vld       = (fill != '0);
    assign o_word      = o_vld ? mem[rd_ptr] : '0;  // head shows through without a read
    assign o_avail     = (frm_cnt != '0) & o_vld;
    assign wr_if.full  = (fill == (ADDR_BITS+1)'(DEPTH));
    assign wr_if.afull = (fill >= (ADDR_BITS+1)'(AFULL_LVL));

    always_ff @(posedge i_txmac_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_if.word;
        end
    end

    always_ff @(posedge i_txmac_clk) begin
        if (i_txmac_srst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            frm_cnt <= '0;
        end else begin
            wr_ptr <= wr_ptr + ADDR_BITS'(push);
            rd_ptr <= rd_ptr + ADDR_BITS'(pop);
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;  // idle, or one in and one out
            endcase
            case ({push & wr_if.word.eof, pop & o_word.eof})
                2'b10:   frm_cnt <= frm_cnt + 1'b1;  // a frame just completed
                2'b01:   frm_cnt <= frm_cnt - 1'b1;  // a frame just left
                default: frm_cnt <= frm_cnt;
            endcase
        end
    end

endmodule

//--- verilog/udp_packetizer_top.sv
`timescale 1ns/1ps

module udp_packetizer_top (
    input  logic                     i_txmac_clk,
    input  logic                     i_txmac_srst,
    input  logic                     i_start,
    output logic                     o_start_ack,
    output logic                     o_done,
    output logic                     o_data_byte_rd,
    input  logic                     i_data_byte_vld,
    input  eth_frame_pkg::byte_t     i_data_byte,
    input  eth_frame_pkg::mac_addr_t i_dest_mac,
    input  eth_frame_pkg::mac_addr_t i_src_mac,
    input  eth_frame_pkg::ip_addr_t  i_dest_ip,
    input  eth_frame_pkg::ip_addr_t  i_src_ip,
    input  eth_frame_pkg::udp_port_t i_dest_port,
    input  eth_frame_pkg::udp_port_t i_src_port,
    input  eth_frame_pkg::len16_t    i_udp_payload_bytes,
    input  logic                     i_seq_num_prsnt,
    input  udp_pktzr_pkg::seq_num_t  i_seq_num,
    output logic                     o_eth_avail,
    output logic                     o_eth_eof,
    output logic                     o_eth_byte_vld,
    output eth_frame_pkg::byte_t     o_eth_byte,
    input  logic                     i_eth_byte_rd,
    output logic                     o_fifo_full,
    output logic                     o_fifo_afull
);

    logic                      csum_start;  // one pulse per accepted frame
    eth_frame_pkg::len16_t     total_len;
    eth_frame_pkg::len16_t     csum;
    udp_pktzr_pkg::fifo_word_t head;        // word at the front of the buffer

    frame_wr_if wr_if ();

    assign o_eth_byte   = head.data;
    assign o_eth_eof    = head.eof;  // level on the final byte of the frame
    assign o_fifo_full  = wr_if.full;
    assign o_fifo_afull = wr_if.afull;

    ipv4_csum_pipe u_csum (
        .i_txmac_clk (i_txmac_clk),
        .i_txmac_srst(i_txmac_srst),
        .i_start     (csum_start),
        .i_total_len (total_len),
        .i_src_ip    (i_src_ip),   // still held by the user in the pulse cycle
        .i_dest_ip   (i_dest_ip),
        .o_csum      (csum)
    );

    udp_frame_builder u_builder (
        .i_txmac_clk        (i_txmac_clk),
        .i_txmac_srst       (i_txmac_srst),
        .i_start            (i_start),
        .o_start_ack        (o_start_ack),
        .o_done             (o_done),
        .o_data_byte_rd     (o_data_byte_rd),
        .i_data_byte_vld    (i_data_byte_vld),
        .i_data_byte        (i_data_byte),
        .i_dest_mac         (i_dest_mac),
        .i_src_mac          (i_src_mac),
        .i_dest_ip          (i_dest_ip),
        .i_src_ip           (i_src_ip),
        .i_dest_port        (i_dest_port),
        .i_src_port         (i_src_port),
        .i_udp_payload_bytes(i_udp_payload_bytes),
        .i_seq_num_prsnt    (i_seq_num_prsnt),
        .i_seq_num          (i_seq_num),
        .o_csum_start       (csum_start),
        .o_total_len        (total_len),
        .i_csum             (csum),
        .wr_if              (wr_if.builder)
    );

    frame_fifo u_fifo (
        .i_txmac_clk (i_txmac_clk),
        .i_txmac_srst(i_txmac_srst),
        .wr_if       (wr_if.buffer),
        .i_rd        (i_eth_byte_rd),
        .o_word      (head),
        .o_vld       (o_eth_byte_vld),
        .o_avail     (o_eth_avail)
    );

endmodule

//--- sim/udp_packetizer_asserts.sv
`timescale 1ns/1ps

module udp_packetizer_asserts (
    input logic i_txmac_clk,
    input logic i_txmac_srst,
    input logic o_start_ack,
    input logic o_fifo_full,
    input logic o_eth_byte_vld,
    input logic i_eth_byte_rd
);

    // the builder leaves idle on the ack edge, so a second ack cycle means a double start
    ack_single_cycle: assert property (@(posedge i_txmac_clk) disable iff (i_txmac_srst)
        o_start_ack |=> !o_start_ack)
        else $error("o_start_ack stayed high for more than one cycle");

    no_fifo_full: assert property (@(posedge i_txmac_clk) disable iff (i_txmac_srst)
        !o_fifo_full)  // afull gating should keep a full frame of room
        else $error("o_fifo_full went high");

    vld_held_until_read: assert property (@(posedge i_txmac_clk) disable iff (i_txmac_srst)
        (o_eth_byte_vld && !i_eth_byte_rd) |=> o_eth_byte_vld)  // stalled head stays put
        else $error("o_eth_byte_vld fell without a read");

endmodule

bind udp_packetizer_top udp_packetizer_asserts u_asserts (
    .i_txmac_clk   (i_txmac_clk),
    .i_txmac_srst  (i_txmac_srst),
    .o_start_ack   (o_start_ack),
    .o_fifo_full   (o_fifo_full),
    .o_eth_byte_vld(o_eth_byte_vld),
    .i_eth_byte_rd (i_eth_byte_rd)
);

//--- sim/tb_udp_packetizer.sv
`timescale 1ns/1ps

module tb_udp_packetizer;

    localparam int CYCLE_LIMIT = 20000;  // all tests together need a few thousand cycles

    logic                     i_txmac_clk;
    logic                     i_txmac_srst;
    logic                     i_start;
    logic                     o_start_ack;
    logic                     o_done;
    logic                     o_data_byte_rd;
    logic                     i_data_byte_vld;
    eth_frame_pkg::byte_t     i_data_byte;
    eth_frame_pkg::mac_addr_t i_dest_mac;
    eth_frame_pkg::mac_addr_t i_src_mac;
    eth_frame_pkg::ip_addr_t  i_dest_ip;
    eth_frame_pkg::ip_addr_t  i_src_ip;
    eth_frame_pkg::udp_port_t i_dest_port;
    eth_frame_pkg::udp_port_t i_src_port;
    eth_frame_pkg::len16_t    i_udp_payload_bytes;
    logic                     i_seq_num_prsnt;
    udp_pktzr_pkg::seq_num_t  i_seq_num;
    logic                     o_eth_avail;
    logic                     o_eth_eof;
    logic                     o_eth_byte_vld;
    eth_frame_pkg::byte_t     o_eth_byte;
    logic                     i_eth_byte_rd;
    logic                     o_fifo_full;
    logic                     o_fifo_afull;

    integer                   seed;
    int                       cycle_cnt = 0;
    eth_frame_pkg::byte_t     exp_data[$];  // every byte the buffer should still hand out
    logic                     exp_eof[$];

    udp_packetizer_top dut (.*);

    always #10 i_txmac_clk = ~i_txmac_clk;  // 20 ns period

    always @(posedge i_txmac_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input eth_frame_pkg::byte_t act, input eth_frame_pkg::byte_t exp,
                              input string what);
        if (act !== exp) begin
            abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, act, exp));
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, act, exp));
        end
    endtask

    task automatic check_ctrl_low();
        check_bit(o_start_ack, 1'b0, "o_start_ack");  // all eight must sit low around reset
        check_bit(o_done, 1'b0, "o_done");
        check_bit(o_data_byte_rd, 1'b0, "o_data_byte_rd");
        check_bit(o_eth_avail, 1'b0, "o_eth_avail");
        check_bit(o_eth_byte_vld, 1'b0, "o_eth_byte_vld");
        check_bit(o_eth_eof, 1'b0, "o_eth_eof");
        check_bit(o_fifo_full, 1'b0, "o_fifo_full");
        check_bit(o_fifo_afull, 1'b0, "o_fifo_afull");
    endtask

    function automatic eth_frame_pkg::len16_t ref_csum(input eth_frame_pkg::len16_t tot,
                                                       input eth_frame_pkg::ip_addr_t src,
                                                       input eth_frame_pkg::ip_addr_t dst);
        logic [31:0] sum;
        sum = 32'h4500 + 32'(tot) + 32'hff11 + 32'(src[31:16]) + 32'(src[15:0]) +
              32'(dst[31:16]) + 32'(dst[15:0]);  // id, flags, fragment and checksum are zero
        while (sum[31:16] != 16'h0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);  // ones' complement end-around carry
        end
        return ~sum[15:0];
    endfunction

    function automatic void expect_byte(input eth_frame_pkg::byte_t b, input logic eof);
        exp_data.push_back(b);
        exp_eof.push_back(eof);
    endfunction

    task automatic expect_header();
        eth_frame_pkg::len16_t tot;
        logic [335:0]          hdr;  // 42 bytes, the first one on top
        tot = i_udp_payload_bytes + 16'd28;
        hdr = {i_dest_mac, i_src_mac, 16'h0800, 16'h4500, tot, 32'h0, 8'hff, 8'h11,
               ref_csum(tot, i_src_ip, i_dest_ip), i_src_ip, i_dest_ip, i_src_port,
               i_dest_port, 16'(i_udp_payload_bytes + 16'd8), 16'h0};
        for (int i = 41; i >= 0; i--) begin
            expect_byte(hdr[i*8 +: 8], 1'b0);
        end
    endtask

    // requests one frame, feeds its payload with gap_pct percent idle cycles, waits for o_done
    task automatic send_frame(input eth_frame_pkg::len16_t plen, input logic seq_on,
                              input int gap_pct);
        eth_frame_pkg::byte_t pay[$];
        eth_frame_pkg::byte_t b;
        int                   idx;
        int unsigned          r;
        idx = 0;
        @(posedge i_txmac_clk);
        i_dest_mac          <= {16'($random(seed)), 32'($random(seed))};
        i_src_mac           <= {16'($random(seed)), 32'($random(seed))};
        i_dest_ip           <= 32'($random(seed));
        i_src_ip            <= 32'($random(seed));
        i_dest_port         <= 16'($random(seed));
        i_src_port          <= 16'($random(seed));
        i_seq_num           <= 32'($random(seed));
        i_udp_payload_bytes <= plen;
        i_seq_num_prsnt     <= seq_on;
        i_start             <= 1'b1;  // level request, dropped once the ack shows up
        @(posedge i_txmac_clk);
        expect_header();  // fields have settled by now
        for (int i = 0; i < (seq_on ? 4 : 0); i++) begin
            expect_byte(i_seq_num[31-8*i -: 8], i == int'(plen) - 1);  // network order
        end
        for (int i = (seq_on ? 4 : 0); i < int'(plen); i++) begin
            b = 8'($random(seed));
            pay.push_back(b);
            expect_byte(b, i == int'(plen) - 1);
        end
        while (o_start_ack !== 1'b1) begin
            @(posedge i_txmac_clk);
        end
        i_start <= 1'b0;
        while (o_done !== 1'b1) begin
            @(posedge i_txmac_clk);
            if (o_data_byte_rd && i_data_byte_vld) begin
                idx++;  // byte taken at this edge
            end
            r = $random(seed);
            if (idx < pay.size() && (r % 100) >= gap_pct) begin
                i_data_byte_vld <= 1'b1;
                i_data_byte     <= pay[idx];
            end else begin
                i_data_byte_vld <= 1'b0;  // random gap in the source
            end
        end
        i_data_byte_vld <= 1'b0;
        check_bit(idx == pay.size(), 1'b1, "every payload byte taken exactly once");
        repeat (2) begin
            @(posedge i_txmac_clk);
            check_bit(o_done, 1'b0, "o_done after its pulse");  // single pulse only
        end
    endtask

    // pops bytes until one eof and compares each against the model queue
    task automatic read_frame();
        logic got_eof;
        got_eof = 1'b0;
        @(posedge i_txmac_clk);
        i_eth_byte_rd <= 1'b1;
        while (!got_eof) begin
            @(posedge i_txmac_clk);
            if (i_eth_byte_rd && o_eth_byte_vld) begin  // this edge pops the head
                if (exp_data.size() == 0) begin
                    abort_run("the buffer returned more bytes than were written");
                end
                check_byte(o_eth_byte, exp_data.pop_front(), "o_eth_byte");
                check_bit(o_eth_eof, exp_eof.pop_front(), "o_eth_eof");
                got_eof = o_eth_eof;
            end
        end
        i_eth_byte_rd <= 1'b0;
    endtask

    task automatic test_reset();
        @(posedge i_txmac_clk);
        for (int c = 2; c <= 5; c++) begin
            @(posedge i_txmac_clk);
            if (c == 3) begin
                i_txmac_srst <= 1'b0;  // third reset edge is the last one
            end
            check_ctrl_low();
        end
    endtask

    task automatic test_single_frame();
        send_frame(16'd30, 1'b0, 0);
        read_frame();
    endtask

    task automatic test_seq_frames();
        send_frame(16'd20, 1'b1, 0);
        read_frame();
        send_frame(16'd4, 1'b1, 0);  // eof lands on the last sequence byte
        read_frame();
    endtask

    task automatic test_payload_gaps();
        send_frame(16'd64, 1'b0, 40);
        send_frame(16'd37, 1'b1, 50);
        read_frame();
        read_frame();
    endtask

    task automatic test_queued_frames();
        send_frame(16'd10, 1'b1, 0);
        send_frame(16'd25, 1'b0, 0);
        send_frame(16'd46, 1'b0, 20);
        @(posedge i_txmac_clk);
        check_bit(o_eth_avail, 1'b1, "o_eth_avail with three frames queued");
        for (int f = 0; f < 3; f++) begin
            read_frame();
            @(posedge i_txmac_clk);
            check_bit(o_eth_avail, f < 2, "o_eth_avail after a frame is read");
        end
    endtask

    task automatic test_buffer_limit();
        send_frame(16'd600, 1'b0, 0);  // 642 words stored, above the 530 word level
        @(posedge i_txmac_clk);
        check_bit(o_fifo_afull, 1'b1, "o_fifo_afull with a large frame stored");
        i_start <= 1'b1;
        repeat (20) begin
            @(posedge i_txmac_clk);
            check_bit(o_start_ack, 1'b0, "o_start_ack while almost full");
            check_bit(o_fifo_afull, 1'b1, "o_fifo_afull while nothing is read");
        end
        i_start <= 1'b0;
        read_frame();
        send_frame(16'd50, 1'b1, 0);
        read_frame();
    endtask

    initial begin
        seed                = 9385;
        i_txmac_clk         = 1'b0;
        i_txmac_srst        <= 1'b1;
        i_start             <= 1'b0;
        i_data_byte_vld     <= 1'b0;
        i_data_byte         <= '0;
        i_dest_mac          <= '0;
        i_src_mac           <= '0;
        i_dest_ip           <= '0;
        i_src_ip            <= '0;
        i_dest_port         <= '0;
        i_src_port          <= '0;
        i_udp_payload_bytes <= '0;
        i_seq_num_prsnt     <= 1'b0;
        i_seq_num           <= '0;
        i_eth_byte_rd       <= 1'b0;
        test_reset();
        test_single_frame();
        test_seq_frames();
        test_payload_gaps();
        test_queued_frames();
        test_buffer_limit();
        if (exp_data.size() != 0) begin
            abort_run("bytes were expected from the buffer but never read");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- files.f
verilog/eth_frame_pkg.sv
verilog/udp_pktzr_pkg.sv
verilog/frame_wr_if.sv
verilog/ipv4_csum_pipe.sv
verilog/udp_frame_builder.sv
verilog/frame_fifo.sv
verilog/udp_packetizer_top.sv
sim/udp_packetizer_asserts.sv
sim/tb_udp_packetizer.sv

//--- run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_udp_packetizer > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_udp_packetizer > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
